//--- project.f
piano_pkg.sv
spi_frame_rx.sv
envelope_timer.sv
envelope_shaper.sv
voice_mixer.sv
dac_frame_fsm.sv
dac_shifter.sv
piano_top.sv
tb_clock_gen.sv
tb_piano.sv

//--- tb_piano.sv
// synthesizer testbench that checks decoded DAC samples against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_piano
    import piano_pkg::*;
;

    localparam int SCK_HALF      = 4;
    localparam int BIT_CYCLES    = 2 * SCK_HALF;
    localparam int FRAME_CYCLES  = FRAME_BITS * BIT_CYCLES;
    localparam int DAC_FRAME     = (DAC_HEADER_BITS + DAC_DATA_BITS) * DAC_BIT_CYCLES
                                   + DAC_LOAD_CYCLES + DAC_LDAC_CYCLES + DAC_GAP_CYCLES;
    localparam int ENV_CYCLES    = ENV_STEPS * ENV_STEP_CYCLES;
    localparam int NUM_ENV_TESTS = 4;
    localparam int TEST_CYCLES   = 3 * FRAME_CYCLES + 16 * BIT_CYCLES + 4 * DAC_FRAME
                                   + NUM_ENV_TESTS * (2 * FRAME_CYCLES + ENV_CYCLES + 8 * DAC_FRAME);
    localparam int CYCLE_LIMIT   = TEST_CYCLES * 6 / 5;

    // gains in 128ths with step 0 in the low byte
    localparam logic [16*8-1:0] GAINS_128 = {
        8'd8,  8'd16, 8'd28, 8'd40, 8'd52,  8'd64,  8'd76, 8'd84,
        8'd92, 8'd100, 8'd112, 8'd128, 8'd48, 8'd36, 8'd24, 8'd14
    };

    logic  clk;
    logic  reset;
    logic  sck;
    logic  sdi;
    note_t led;
    logic  dclk;
    logic  data;
    logic  load;
    logic  ldac;

    int    value_errors = 0;
    int    proto_errors = 0;
    int    cycles;
    int    seed_dummy;
    string test_name = "reset";
    bit    env_mode = 0;       // low while every sample must be zero
    bit    started;
    bit    env_finished;
    int    last_step;
    int    cur_count;
    note_t cur_note [3];

    // DAC line decoder state
    note_t sample_q [$];
    note_t led_q [$];
    int    frames_seen = 0;
    int    rises;
    int    load_low;
    int    ldac_low;
    bit    load_seen;
    logic  dclk_q;
    logic  load_q;
    logic  ldac_q;
    note_t shreg;
    note_t led_snap;

    tb_clock_gen clock_i (
        .clk   (clk),
        .reset (reset)
    );

    piano_top dut_i (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .sdi   (sdi),
        .led   (led),
        .dclk  (dclk),
        .data  (data),
        .load  (load),
        .ldac  (ldac)
    );

    task automatic value_mismatch(input string name, input int expected, input int actual);
        value_errors++;
        $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    task automatic protocol_fault(input string msg);
        proto_errors++;
        $display("%s", msg);
    endtask

    task automatic print_counts();
        $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    endtask

    function automatic note_t shape(input note_t n, input int step);
        logic [7:0] mask;
        note_t      acc;
        mask = GAINS_128[step*8 +: 8];
        acc  = '0;
        for (int k = 0; k < 8; k++)
        begin
            if (mask[k])
                acc = acc + (n >> (7 - k));   // each term truncated on its own
        end
        return acc;
    endfunction

    function automatic note_t mix(input note_t a, input note_t b, input note_t c, input int active);
        logic [9:0] s;
        logic [9:0] q;
        s = {2'b00, a} + {2'b00, b} + {2'b00, c};
        q = (s >> 2) + (s >> 4) + (s >> 6) + (s >> 8);
        case (active)
            1:       return note_t'(s);
            2:       return note_t'(s >> 1);
            3:       return note_t'(q);
            default: return '0;
        endcase
    endfunction

    // all voices of a test run in lockstep, so none is done while the envelope runs
    function automatic note_t expected_sample(input int step);
        return mix(shape(cur_note[0], step), shape(cur_note[1], step),
                   shape(cur_note[2], step), cur_count);
    endfunction

    // led is sampled a couple of cycles after the capture, so the next step is allowed too
    function automatic bit led_ok(input int s, input note_t got, input note_t led_got);
        bit ok;
        ok = 1'b0;
        for (int t = s; t < ENV_STEPS; t++)
        begin
            if (expected_sample(t) == got)
            begin
                if (led_got == shape(cur_note[0], t))
                    ok = 1'b1;
                if (t < ENV_STEPS - 1 && led_got == shape(cur_note[0], t + 1))
                    ok = 1'b1;
                if (t == ENV_STEPS - 1 && led_got == 0)
                    ok = 1'b1;
            end
        end
        return ok;
    endfunction

    function automatic frame_word_t make_frame(input logic [1:0] count, input note_t n1,
                                               input note_t n2, input note_t n3);
        frame_word_t fw;
        fw.raw          = '0;
        fw.fields.count = count;
        fw.fields.note1 = n1;
        fw.fields.note2 = n2;
        fw.fields.note3 = n3;
        return fw;
    endfunction

    function automatic note_t random_note();
        return note_t'(64 + $urandom % 192);   // large enough that no step shapes to zero
    endfunction

    task automatic send_bit(input logic b);
        @(negedge clk);
        sdi = b;
        sck = 1'b0;
        repeat (SCK_HALF - 1) @(negedge clk);
        @(negedge clk);
        sck = 1'b1;
        repeat (SCK_HALF - 1) @(negedge clk);
    endtask

    task automatic send_frame(input frame_word_t fw);
        for (int i = FRAME_BITS - 1; i >= 0; i--)
            send_bit(fw.raw[i]);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_seen + n;
        wait (frames_seen >= target);
    endtask

    task automatic run_envelope(input string name, input int count, input note_t n);
        test_name = {name, "_clear"};
        env_mode  = 1'b0;
        send_frame(make_frame(2'd0, 8'd0, 8'd0, 8'd0));   // zero notes rearm the timers
        wait_frames(2);
        test_name    = name;
        cur_count    = count;
        cur_note[0]  = n;
        cur_note[1]  = (count >= 2) ? n : 8'd0;
        cur_note[2]  = (count == 3) ? n : 8'd0;
        last_step    = 0;
        started      = 1'b0;
        env_finished = 1'b0;
        env_mode     = 1'b1;
        send_frame(make_frame(count[1:0], cur_note[0], cur_note[1], cur_note[2]));
        wait (env_finished);
        wait_frames(2);
    endtask

    task automatic check_sample(input note_t got, input note_t led_got);
        int found;
        if (!env_mode)
        begin
            if (got != 0)
                value_mismatch(test_name, 0, got);
        end
        else if (got == 0)
        begin
            if (started && !env_finished)
            begin
                if (last_step != ENV_STEPS - 1)
                    protocol_fault($sformatf("%s: samples dropped to zero at step %0d",
                                             test_name, last_step));
                env_finished = 1'b1;
            end
        end
        else if (env_finished)
            value_mismatch(test_name, 0, got);
        else
        begin
            found = -1;
            for (int s = (started ? last_step : 0); s < ENV_STEPS && found < 0; s++)
            begin
                if (expected_sample(s) == got)
                    found = s;
            end
            if (found < 0)
                value_mismatch(test_name, expected_sample(last_step), got);
            else
            begin
                if (!started && found != 0)
                    protocol_fault($sformatf("%s: envelope started at step %0d, not step 0",
                                             test_name, found));
                started   = 1'b1;
                last_step = found;
                if (!led_ok(found, got, led_got))
                    value_mismatch({test_name, "_led"}, shape(cur_note[0], found), led_got);
            end
        end
    endtask

    // DAC pins are decoded on falling edges where they are settled
    always @(negedge clk)
    begin
        if (reset)
        begin
            rises     = 0;
            load_low  = 0;
            ldac_low  = 0;
            load_seen = 1'b0;
            dclk_q    = 1'b0;
            load_q    = 1'b1;
            ldac_q    = 1'b1;
            shreg     = '0;
        end
        else
        begin
            if (dclk && !dclk_q)
            begin
                rises++;
                if (rises == 1)
                    led_snap = led;
                if (rises <= DAC_HEADER_BITS)
                begin
                    if (data !== 1'b0)
                        protocol_fault("data was high during a header bit");
                end
                else
                    shreg = {shreg[NOTE_W-2:0], data};
                if (!load || !ldac)
                    protocol_fault("dclk rose while load or ldac was low");
            end
            if (!load && !ldac)
                protocol_fault("load and ldac were low at the same time");
            if (!load && load_q)
            begin
                if (rises != DAC_HEADER_BITS + DAC_DATA_BITS)
                    protocol_fault($sformatf("dclk rose %0d times before load fell", rises));
                sample_q.push_back(shreg);
                led_q.push_back(led_snap);
                frames_seen++;
                rises = 0;
            end
            if (!load)
                load_low++;
            if (load && !load_q)
            begin
                if (load_low != DAC_LOAD_CYCLES)
                    protocol_fault($sformatf("load pulse lasted %0d cycles", load_low));
                load_low  = 0;
                load_seen = 1'b1;
            end
            if (!ldac && ldac_q)
            begin
                if (!load_seen)
                    protocol_fault("ldac fell without a load pulse before it");
                load_seen = 1'b0;
            end
            if (!ldac)
                ldac_low++;
            if (ldac && !ldac_q)
            begin
                if (ldac_low != DAC_LDAC_CYCLES)
                    protocol_fault($sformatf("ldac pulse lasted %0d cycles", ldac_low));
                ldac_low = 0;
            end
            dclk_q = dclk;
            load_q = load;
            ldac_q = ldac;
        end
    end

    // decoded samples are compared on rising edges so they never race the decoder
    always @(posedge clk)
    begin
        while (sample_q.size() > 0)
            check_sample(sample_q.pop_front(), led_q.pop_front());
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        protocol_fault($sformatf("timeout: run stopped after %0d cycles in %s", cycles, test_name));
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        sck        = 1'b0;
        sdi        = 1'b0;
        seed_dummy = $urandom(93);
        wait (reset == 1'b0);
        @(negedge clk);
        if (load !== 1'b1 || ldac !== 1'b1 || dclk !== 1'b0 || data !== 1'b0)
            protocol_fault("DAC pins not idle right after reset");

        // no run of 16 ones and a trailing zero so only the full sync word arms the receiver
        test_name = "pre_sync";
        send_frame(make_frame(2'd1, 8'h77, 8'h3C, 8'h5A));
        send_frame(make_frame(2'd2, 8'h32, 8'h66, 8'h19));
        wait_frames(3);

        repeat (16) send_bit(1'b1);   // sync word

        run_envelope("one_voice", 1, random_note());
        run_envelope("two_voices", 2, random_note());
        run_envelope("three_voices", 3, random_note());
        run_envelope("restart", 3, random_note());
        wait_frames(1);
        repeat (2) @(posedge clk);

        print_counts();
        if (value_errors == 0 && proto_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source with a 20 ns clock and reset held over the first two edges
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released on a falling edge like the other inputs
    end

endmodule

`default_nettype wire

//--- piano_top.sv
// synthesizer top with the serial note receiver, three envelope voices, mixer and DAC driver
`timescale 1ns/10ps
`default_nettype none

module piano_top
    import piano_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  sck,
    input  logic  sdi,
    output note_t led,
    output logic  dclk,
    output logic  data,
    output logic  load,
    output logic  ldac
);

    note_t                        voice_note   [NUM_VOICES];
    logic [$clog2(ENV_STEPS)-1:0] voice_step   [NUM_VOICES];
    note_t                        voice_shaped [NUM_VOICES];
    logic [NUM_VOICES-1:0]        voice_done;
    logic [1:0]                   voice_count;
    note_t                        mixed;
    logic                         capture;
    logic                         shift;
    logic                         data_en;
    logic                         data_bit;

    spi_frame_rx rx_i (
        .clk         (clk),
        .reset       (reset),
        .sck         (sck),
        .sdi         (sdi),
        .note1       (voice_note[0]),
        .note2       (voice_note[1]),
        .note3       (voice_note[2]),
        .voice_count (voice_count)
    );

    for (genvar v = 0; v < NUM_VOICES; v++)
    begin : g_voice
        envelope_timer timer_i (
            .clk   (clk),
            .reset (reset),
            .note  (voice_note[v]),
            .step  (voice_step[v]),
            .done  (voice_done[v])
        );

        envelope_shaper shaper_i (
            .clk    (clk),
            .reset  (reset),
            .note   (voice_note[v]),
            .step   (voice_step[v]),
            .done   (voice_done[v]),
            .shaped (voice_shaped[v])
        );
    end

    voice_mixer mixer_i (
        .clk         (clk),
        .reset       (reset),
        .shaped1     (voice_shaped[0]),
        .shaped2     (voice_shaped[1]),
        .shaped3     (voice_shaped[2]),
        .done1       (voice_done[0]),
        .done2       (voice_done[1]),
        .done3       (voice_done[2]),
        .voice_count (voice_count),
        .mixed       (mixed)
    );

    dac_frame_fsm fsm_i (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .shift   (shift),
        .dclk    (dclk),
        .load    (load),
        .ldac    (ldac),
        .data_en (data_en)
    );

    dac_shifter shifter_i (
        .clk      (clk),
        .reset    (reset),
        .sample   (mixed),
        .capture  (capture),
        .shift    (shift),
        .data_bit (data_bit)
    );

    assign data = data_en & data_bit;   // header bits go out as zeros
    assign led  = voice_shaped[0];

endmodule

`default_nettype wire

//--- dac_shifter.sv
// DAC data shifter that holds one mixed sample per frame and sends it MSB first
`timescale 1ns/10ps
`default_nettype none

module dac_shifter
    import piano_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  note_t sample,
    input  logic  capture,
    input  logic  shift,
    output logic  data_bit
);

    note_t sreg;

    always_ff @(posedge clk)
    begin
        if (capture)
            sreg <= sample;                       // frame start
        else if (shift)
            sreg <= {sreg[NOTE_W-2:0], 1'b0};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            data_bit <= 1'b0;
        else if (shift)
            data_bit <= sreg[NOTE_W-1];
    end

endmodule

`default_nettype wire

//--- dac_frame_fsm.sv
// DAC frame sequencer for the header bits, data bits, load pulse, ldac pulse and a short gap
`timescale 1ns/10ps
`default_nettype none

module dac_frame_fsm
    import piano_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic capture,
    output logic shift,
    output logic dclk,
    output logic load,
    output logic ldac,
    output logic data_en
);

    dac_phase_t phase;
    dac_phase_t next_phase;
    logic [$clog2(DAC_BIT_CYCLES)-1:0] cyc_cnt;
    logic [$clog2(DAC_DATA_BITS)-1:0]  bit_cnt;
    logic in_bits;
    logic bit_end;
    logic phase_end;

    assign in_bits = (phase == HEADER) || (phase == DATA);
    assign capture = (phase == HEADER) && (bit_cnt == 0) && (cyc_cnt == 0);
    assign shift   = (phase == DATA) && (cyc_cnt == 0);   // next data bit at each bit start

    always_comb
    begin
        bit_end    = 1'b0;
        phase_end  = 1'b0;
        next_phase = HEADER;
        case (phase)
            HEADER:
            begin
                bit_end    = (cyc_cnt == DAC_BIT_CYCLES-1);
                phase_end  = bit_end && (bit_cnt == DAC_HEADER_BITS-1);
                next_phase = DATA;
            end
            DATA:
            begin
                bit_end    = (cyc_cnt == DAC_BIT_CYCLES-1);
                phase_end  = bit_end && (bit_cnt == DAC_DATA_BITS-1);
                next_phase = LOAD;
            end
            LOAD:
            begin
                phase_end  = (cyc_cnt == DAC_LOAD_CYCLES-1);
                next_phase = LDAC;
            end
            LDAC:
            begin
                phase_end  = (cyc_cnt == DAC_LDAC_CYCLES-1);
                next_phase = GAP;
            end
            default:
                phase_end = (cyc_cnt == DAC_GAP_CYCLES-1);   // gap returns to header
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase   <= HEADER;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (phase_end)
        begin
            phase   <= next_phase;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (bit_end)
        begin
            cyc_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
        end
        else
            cyc_cnt <= cyc_cnt + 1'b1;
    end

    // pin outputs are registered so dclk rises a cycle after the data bit settles
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dclk    <= 1'b0;
            load    <= 1'b1;
            ldac    <= 1'b1;
            data_en <= 1'b0;
        end
        else
        begin
            dclk    <= in_bits && (cyc_cnt != 0) && (cyc_cnt <= DAC_BIT_CYCLES/2);
            load    <= (phase != LOAD);
            ldac    <= (phase != LDAC);
            data_en <= (phase == DATA);
        end
    end

    assert property (@(posedge clk) disable iff (reset) load || ldac);

endmodule

`default_nettype wire

//--- voice_mixer.sv
// three-voice mixer that sums the shaped voices and divides by the voices still sounding
`timescale 1ns/10ps
`default_nettype none

module voice_mixer
    import piano_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  note_t      shaped1,
    input  note_t      shaped2,
    input  note_t      shaped3,
    input  logic       done1,
    input  logic       done2,
    input  logic       done3,
    input  logic [1:0] voice_count,
    output note_t      mixed
);

    logic [1:0] n_done;
    logic [1:0] active;
    logic [9:0] sum;
    logic [9:0] third;

    assign n_done = 2'(done1) + 2'(done2) + 2'(done3);
    assign active = (voice_count > n_done) ? voice_count - n_done : 2'd0;
    assign sum    = 10'(shaped1) + 10'(shaped2) + 10'(shaped3);

    // 1/4 + 1/16 + 1/64 + 1/256 is close enough to 1/3
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);

    always_ff @(posedge clk)
    begin
        if (reset)
            mixed <= '0;
        else
        begin
            case (active)
                2'd1:    mixed <= sum[7:0];
                2'd2:    mixed <= sum[8:1];
                2'd3:    mixed <= third[7:0];
                default: mixed <= '0;   // nothing sounding
            endcase
        end
    end

endmodule

`default_nettype wire

//--- envelope_shaper.sv
// envelope shaper that scales a note by the binary-fraction gain of the current step
`timescale 1ns/10ps
`default_nettype none

module envelope_shaper
    import piano_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  note_t                        note,
    input  logic [$clog2(ENV_STEPS)-1:0] step,
    input  logic                         done,
    output note_t                        shaped
);

    logic [7:0] gain;
    note_t      scaled;

    // one truncated term per set mask bit where bit k weighs 2^(k-7)
    always_comb
    begin
        gain   = ENV_GAIN[step];
        scaled = '0;
        for (int k = 0; k < NOTE_W; k++)
        begin
            if (gain[k])
                scaled = scaled + (note >> (NOTE_W - 1 - k));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            shaped <= '0;
        else if (done)
            shaped <= '0;   // voice has died out
        else
            shaped <= scaled;
    end

endmodule

`default_nettype wire

//--- envelope_timer.sv
// per-voice envelope timer that steps through the gain table while the note is held
`timescale 1ns/10ps
`default_nettype none

module envelope_timer
    import piano_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  note_t                        note,
    output logic [$clog2(ENV_STEPS)-1:0] step,
    output logic                         done
);

    logic [$clog2(ENV_STEP_CYCLES)-1:0] cyc_cnt;

    always_ff @(posedge clk)
    begin
        if (reset || note == '0)   // a silent note rearms the envelope
        begin
            cyc_cnt <= '0;
            step    <= '0;
            done    <= 1'b0;
        end
        else if (!done)
        begin
            if (cyc_cnt == ENV_STEP_CYCLES-1)
            begin
                cyc_cnt <= '0;
                if (step == ENV_STEPS-1)
                    done <= 1'b1;   // park on the last step
                else
                    step <= step + 1'b1;
            end
            else
                cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // finished voices always sit on the last step
    assert property (@(posedge clk) disable iff (reset)
        done |-> (step == ENV_STEPS-1));

endmodule

`default_nettype wire

//--- spi_frame_rx.sv
// serial note receiver that syncs sck/sdi into clk, arms on the sync word and latches frames
`timescale 1ns/10ps
`default_nettype none

module spi_frame_rx
    import piano_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sck,
    input  logic       sdi,
    output note_t      note1,
    output note_t      note2,
    output note_t      note3,
    output logic [1:0] voice_count
);

    logic [1:0] sck_sync;
    logic [1:0] sdi_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic       armed;
    logic [$clog2(FRAME_BITS):0] bit_cnt;
    frame_word_t shift_word;
    frame_word_t next_word;

    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign next_word.raw = {shift_word.raw[FRAME_BITS-2:0], sdi_sync[1]};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sck_sync <= '0;
            sdi_sync <= '0;
            sck_prev <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            sdi_sync <= {sdi_sync[0], sdi};
            sck_prev <= sck_sync[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shift_word.raw <= '0;
            armed          <= 1'b0;
            bit_cnt        <= '0;
            note1          <= '0;
            note2          <= '0;
            note3          <= '0;
            voice_count    <= '0;
        end
        else if (sck_rise)
        begin
            shift_word <= next_word;
            if (!armed)
                armed <= (next_word.raw[15:0] == SYNC_WORD);   // counting starts with the next bit
            else if (bit_cnt == FRAME_BITS-1)
            begin
                bit_cnt     <= '0;
                note1       <= next_word.fields.note1;
                note2       <= next_word.fields.note2;
                note3       <= next_word.fields.note3;
                voice_count <= next_word.fields.count;
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // the bit counter only moves once armed and wraps at the frame length
    assert property (@(posedge clk) disable iff (reset)
        (bit_cnt <= FRAME_BITS-1) && (armed || bit_cnt == 0));

endmodule

`default_nettype wire

//--- piano_pkg.sv
// synthesizer package with the frame layout, widths, envelope gain table and DAC timing
`default_nettype none

package piano_pkg;

    localparam int NOTE_W     = 8;
    localparam int FRAME_BITS = 32;
    localparam int NUM_VOICES = 3;

    localparam logic [15:0] SYNC_WORD = 16'hFFFF;   // arms the receiver

    typedef logic [NOTE_W-1:0] note_t;

    // one received frame seen either as the shift word or as its note fields
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        struct packed {
            logic [5:0] pad;
            logic [1:0] count;   // voices requested
            note_t      note3;
            note_t      note2;
            note_t      note1;
        } fields;
    } frame_word_t;

    localparam int ENV_STEPS       = 16;
    localparam int ENV_STEP_CYCLES = 256;

    // bit 7 weighs the whole note and bits 6..0 weigh 1/2 down to 1/128
    // so each value reads directly as the gain in 128ths
    localparam logic [7:0] ENV_GAIN [ENV_STEPS] = '{
        8'd14,  8'd24,  8'd36,  8'd48,    // attack
        8'd128, 8'd112, 8'd100, 8'd92,    // peak and early decay
        8'd84,  8'd76,  8'd64,  8'd52,
        8'd40,  8'd28,  8'd16,  8'd8      // release
    };

    localparam int DAC_BIT_CYCLES  = 8;   // clk cycles per dclk period
    localparam int DAC_HEADER_BITS = 8;
    localparam int DAC_DATA_BITS   = 8;
    localparam int DAC_LOAD_CYCLES = 4;
    localparam int DAC_LDAC_CYCLES = 4;
    localparam int DAC_GAP_CYCLES  = 2;

    typedef enum logic [2:0] {
        HEADER,
        DATA,
        LOAD,
        LDAC,
        GAP
    } dac_phase_t;

endpackage

`default_nettype wire
